// File: include/warDefs_defs.svh
`ifndef WAR_DEFS_SVH
`define WAR_DEFS_SVH

// Card outline in pixels
`define CARD_WIDTH 24
`define CARD_HEIGHT 40

// Rank and suit glyphs
`define GLYPH_SIZE 16
`define GLYPH_BITS 768
`define GLYPH_X_OFFSET 4
`define RANK_Y_OFFSET 2
`define SUIT_Y_OFFSET 23

// Screen positions of the two cards
`define PLAYER_X 30
`define COM_X 200
`define CARD_Y 70

`define BLANK_COLOUR 7 // White

`define LFSR_SEED 16'hACE1 // Must not be zero

`endif

// File: hw/cardPkg.sv
`include "warDefs_defs.svh"

package cardPkg;

	typedef logic [7:0] xCoord; // Screen column
	typedef logic [6:0] yCoord; // Screen row
	typedef logic [2:0] colour; // One bit each of R, G, B

	typedef logic [3:0] rank; // 1 ace .. 13 king
	typedef logic [1:0] suit; // Spade, diamond, club, heart

	typedef logic [5:0] card; // {rank, suit}

	// 16x16 pixels, 3 bits each, first pixel in the top bits
	typedef logic [`GLYPH_BITS-1:0] glyph;

endpackage

// File: hw/gamePkg.sv
package gamePkg;

	typedef enum logic [1:0] {
		WIN_NONE = 2'd0,
		WIN_PLAYER = 2'd1,
		WIN_COM = 2'd2,
		WIN_TIE = 2'd3
	} winner;

	typedef enum logic [3:0] {
		RS_WAIT_DEAL, RS_WAIT_RELEASE, RS_DEAL_PLAYER, RS_DRAW_PLAYER, RS_WAIT_PLAYER,
		RS_DEAL_COM, RS_DRAW_COM, RS_WAIT_COM, RS_DECIDE, RS_HOLD
	} roundState;

	typedef enum logic [2:0] {
		DS_IDLE, DS_BLANK_START, DS_BLANK, DS_RANK_START, DS_RANK, DS_SUIT_START, DS_SUIT
	} drawState;

endpackage

// File: hw/glyphRom.sv
`timescale 1ns/1ns

module glyphRom (
	input logic clock,
	input cardPkg::rank cardRank,
	input cardPkg::suit cardSuit,
	output cardPkg::glyph rankGlyph,
	output cardPkg::glyph suitGlyph
);
	import cardPkg::*;

	localparam glyph ACE = 768'hFFFFFFFFFFFFFFFE00000FFFFFF03FFF81FFFF81FFFFF03FFF8FFFFFFE3FFF8FFFFFFE3FFF8FFFFFFE3FFF800000003FFF8FFFFFFE3FFF8FFFFFFE3FFF8FFFFFFE3FFF8FFFFFFE3FFF8FFFFFFE3FFF8FFFFFFE3FFF8FFFFFFE3FFFFFFFFFFFFF;
	localparam glyph TWO = 768'hFFFE0003FFFFFFF000007FFFFF803FE00FFFFF81FFFC0FFFFFFFFFFC0FFFFFFFFFFC0FFFFFFFFFE00FFFFFFFFF007FFFFFFFF803FFFFFFFFC01FFFFFFFFE00FFFFFFFFF007FFFFFFFF803FFFFFFFFF800000003FFF800000003FFFFFFFFFFFFF;
	localparam glyph THREE = 768'hFFFE00007FFFFFF000000FFFFF803FFC01FFFF81FFFF81FFFFFFFFFF81FFFFFFFFFC01FFFFFFFFE00FFFFFFFFF007FFFFFFFFFE00FFFFFFFFFFC01FFFFFFFFFF81FFFF81FFFF81FFFF803FFC01FFFFF000000FFFFFFE00007FFFFFFFFFFFFFFF;
	localparam glyph FOUR = 768'hFFFFFFE00FFFFFFFFF000FFFFFFFF8000FFFFFFFC01C0FFFFFFE00FC0FFFFFF007FC0FFFFF803FFC0FFFFC01FFFC0FFFE00FFFFC0FFFE0000000003FE0000000003FFFFFFFFC0FFFFFFFFFFC0FFFFFFFFFFC0FFFFFFFFFFC0FFFFFFFFFFC0FFF;
	localparam glyph FIVE = 768'hFC000000003FFC000000003FFC0FFFFFFFFFFC0FFFFFFFFFFC0FFFFFFFFFFC0E00007FFFFC0000000FFFFC01FFFC01FFFFFFFFFF803FFFFFFFFFF03FFC0FFFFFF03FFC01FFFFF03FFF803FFF803FFFF0000001FFFFFE00000FFFFFFFFFFFFFFF;
	localparam glyph SIX = 768'hFFFFFFFFFFFFFFFFF8007FFFFFFFC7FF8FFFFFFE3FFFF1FFFFFE3FFFFFFFFFF1FFFFFFFFFFF1FFFFFFFFFFF000007FFFFFF03FFF8FFFFFF1FFFFF1FFFFF1FFFFF1FFFFF1FFFFF1FFFFF1FFFFF1FFFFF1FFFFFE3FFF8FFFFFFFC0007FFF;
	localparam glyph SEVEN = 768'hFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF000000FFFFFFFFFFF8FFFFFFFFFFF8FFFFFFFFFFC7FFFFFFFFFE3FFFFFFFFFF03FFFFFFFFFF1FFFFFFFFFFF1FFFFFFFFFFF1FFFFFFFFFFF1FFFFFFFFFFF1FFFFFFFFFFF1FFFFFFFFFFFFFFFFF;
	localparam glyph EIGHT = 768'hFFFE00007FFFFFF000000FFFFF803FFC01FFFF81FFFF81FFFF81FFFF81FFFF803FFC01FFFFF007E00FFFFFFE00007FFFFFF007E00FFFFF803FFC01FFFF81FFFF81FFFF81FFFF81FFFF803FFC01FFFFF000000FFFFFFE00007FFFFFFFFFFFFFFF;
	localparam glyph NINE = 768'hFFFE0003FFFFFFF1FFFC7FFFFF8FFFFF8FFFFF8FFFFF8FFFFF8FFFFF8FFFFF8FFFFF8FFFFF8FFFFF8FFFFFF1FFFC0FFFFFFE00000FFFFFFFFFFF8FFFFFFFFFFF8FFFFFFFFFFC7FFFFF8FFFFC7FFFFFF1FFE3FFFFFFFE001FFFFFFFFFFFFFFFFF;
	localparam glyph TEN = 768'hFFFFFFFFFFFFFFFFFFFFFFFFFC7FC0000FFFFC7E3FFFF1FFFC7E3FFFF1FFFC7E3FFFF1FFFC7E3FFFF1FFFC7E3FFFF1FFFC7E3FFFF1FFFC7E3FFFF1FFFC7E3FFFF1FFFC7E3FFFF1FFFC7FC0000FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF;
	localparam glyph JACK = 768'hFFFFFFFFFFFFFFFFFFFFFFFFFFF0000001FFFFFFFF1FFFFFFFFFFF1FFFFFFFFFFF1FFFFFFFFFFF1FFFFFFFFFFF1FFFFFFFFFFF1FFFFFFFFFFF1FFFFFFF8FFF1FFFFFFF81F81FFFFFFFF000FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF;
	localparam glyph QUEEN = 768'hFFFE0003FFFFFF81FFFC0FFFFC7FFFFFF1FFE3FFFFFFFE3FE3FFFFFFFE3F1FFFFFFFFFC71FFFFFFFFFC71FFFFFFFFFC71FFFFFFFFFC71FFFFFFFFFC7E3FFFFFC7E3FE3FFFFFF8E3FFC7FFFFFF1FFFF81FFFC0E3FFFFE0003FFC7FFFFFFFFFFF8;
	localparam glyph KING = 768'hFF81FFFFFE07FF81FFFFF03FFF81FFFF81FFFF81FFFC0FFFFF81FFE07FFFFF81FF03FFFFFF81F81FFFFFFF8000FFFFFFFF81F81FFFFFFF81FF03FFFFFF81FFE07FFFFF81FFFC0FFFFF81FFFF81FFFF81FFFFF03FFF81FFFFFE07FF81FFFFFFC0;
	localparam glyph SPADE = 768'hFFFFF81FFFFFFFFFC003FFFFFFFE00007FFFFFF000000FFFFFF000000FFFFF80000001FFFF80000001FFFC000000003FFC000000003FE00000000007E00000000007E001F81F8007FC0FF81FF03FFFFFF81FFFFFFFFE00007FFFFFFFFFFFFFFF;
	localparam glyph DIAMOND = 768'hFFFFFCFFFFFFFFFFE49FFFFFFFFF2493FFFFFFF924927FFFFFF924927FFFFFC924924FFFFE49249249FFF2492492493FF2492492493FFE49249249FFFFC924924FFFFFF924927FFFFFF924927FFFFFFF2493FFFFFFFFE49FFFFFFFFFFCFFFFFF;
	localparam glyph CLUB = 768'hFFFFC01FFFFFFFFE0003FFFFFFF000007FFFFFF000007FFFFFFE0003FFFFFC0FC01F81FFE001C01C003F000000000007000000000007000000000007E001F8FC003FFC0FF8FF81FFFFFFF8FFFFFFFFFFC01FFFFFFFFE0003FFFFFFFFFFFFFFFF;
	localparam glyph HEART = 768'hFFFFFFFFFFFFFFFFFFFFFFFFFFC93FFE49FFFE4927F2493FF24924924927F24924924927F24924924927F24924924927FE492492493FFE492492493FFFC9249249FFFFF924924FFFFFFF24927FFFFFFFE493FFFFFFFFFC9FFFFFFFFFFFFFFFFF;

	always_ff @(posedge clock) begin
		case (cardRank)
			4'd1: rankGlyph <= ACE;
			4'd2: rankGlyph <= TWO;
			4'd3: rankGlyph <= THREE;
			4'd4: rankGlyph <= FOUR;
			4'd5: rankGlyph <= FIVE;
			4'd6: rankGlyph <= SIX;
			4'd7: rankGlyph <= SEVEN;
			4'd8: rankGlyph <= EIGHT;
			4'd9: rankGlyph <= NINE;
			4'd10: rankGlyph <= TEN;
			4'd11: rankGlyph <= JACK;
			4'd12: rankGlyph <= QUEEN;
			4'd13: rankGlyph <= KING;
			default: rankGlyph <= '0; // Not a valid rank
		endcase
		case (cardSuit)
			2'd0: suitGlyph <= SPADE;
			2'd1: suitGlyph <= DIAMOND;
			2'd2: suitGlyph <= CLUB;
			default: suitGlyph <= HEART;
		endcase
	end

endmodule

// File: hw/blankPainter.sv
`timescale 1ns/1ns
`include "warDefs_defs.svh"

module blankPainter (
	input logic clock,
	input logic resetN,
	input logic start,
	input cardPkg::xCoord originX,
	input cardPkg::yCoord originY,
	output cardPkg::xCoord xOut,
	output cardPkg::yCoord yOut,
	output logic pixelValid,
	output logic done
);
	import cardPkg::*;

	logic running;
	logic [4:0] col; // 0 .. CARD_WIDTH-1
	logic [5:0] row; // 0 .. CARD_HEIGHT-1
	logic lastPixel;
	xCoord baseX;
	yCoord baseY;

	assign lastPixel = (col == 5'(`CARD_WIDTH - 1)) && (row == 6'(`CARD_HEIGHT - 1));

	always_ff @(posedge clock) begin
		if (!resetN) begin
			running <= 1'b0;
			pixelValid <= 1'b0;
			done <= 1'b0;
		end else begin
			pixelValid <= running;
			done <= pixelValid && !running; // Cycle after the last pixel
			if (start)
				running <= 1'b1;
			else if (running && lastPixel)
				running <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			baseX <= originX;
			baseY <= originY;
			col <= '0;
			row <= '0;
		end else if (running) begin
			xOut <= baseX + {3'b000, col};
			yOut <= baseY + {1'b0, row};
			if (col == 5'(`CARD_WIDTH - 1)) begin
				col <= '0;
				row <= row + 6'd1;
			end else
				col <= col + 5'd1;
		end
	end

endmodule

// File: hw/glyphPainter.sv
`timescale 1ns/1ns
`include "warDefs_defs.svh"

module glyphPainter (
	input logic clock,
	input logic resetN,
	input logic start,
	input cardPkg::xCoord originX,
	input cardPkg::yCoord originY,
	input cardPkg::glyph glyphData,
	output cardPkg::xCoord xOut,
	output cardPkg::yCoord yOut,
	output cardPkg::colour colourOut,
	output logic pixelValid,
	output logic done
);
	import cardPkg::*;

	logic running;
	logic [3:0] col;
	logic [3:0] row;
	logic lastPixel;
	xCoord baseX;
	yCoord baseY;
	glyph dataReg; // Shifts left one pixel per cycle

	assign lastPixel = (col == 4'(`GLYPH_SIZE - 1)) && (row == 4'(`GLYPH_SIZE - 1));

	always_ff @(posedge clock) begin
		if (!resetN) begin
			running <= 1'b0;
			pixelValid <= 1'b0;
			done <= 1'b0;
		end else begin
			pixelValid <= running;
			done <= pixelValid && !running;
			if (start)
				running <= 1'b1;
			else if (running && lastPixel)
				running <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			baseX <= originX;
			baseY <= originY;
			dataReg <= glyphData;
			col <= '0;
			row <= '0;
		end else if (running) begin
			xOut <= baseX + {4'b0000, col};
			yOut <= baseY + {3'b000, row};
			colourOut <= dataReg[`GLYPH_BITS-1 -: 3]; // Top bits hold the next pixel
			dataReg <= dataReg << 3;
			col <= col + 4'd1; // Wraps to the next row
			if (col == 4'(`GLYPH_SIZE - 1))
				row <= row + 4'd1;
		end
	end

endmodule

// File: hw/cardRenderer.sv
`timescale 1ns/1ns
`include "warDefs_defs.svh"

module cardRenderer (
	input logic clock,
	input logic resetN,
	input logic drawCard,
	input cardPkg::xCoord originX,
	input cardPkg::yCoord originY,
	input cardPkg::card dealtCard,
	output cardPkg::xCoord x,
	output cardPkg::yCoord y,
	output cardPkg::colour pixelColour,
	output logic plot,
	output logic cardDrawn
);
	import cardPkg::*;
	import gamePkg::*;

	drawState state, nextState;
	card cardReg;
	xCoord baseX;
	yCoord baseY;
	rank cardRank;
	suit cardSuit;
	glyph rankGlyph, suitGlyph;

	logic blankStart, rankStart, suitStart;
	logic blankValid, rankValid, suitValid;
	logic blankDone, rankDone, suitDone;
	xCoord blankX, rankX, suitX;
	yCoord blankY, rankY, suitY;
	colour rankColour, suitColour;

	assign cardRank = cardReg[5:2];
	assign cardSuit = cardReg[1:0];

	assign blankStart = (state == DS_BLANK_START);
	assign rankStart = (state == DS_RANK_START);
	assign suitStart = (state == DS_SUIT_START);

	always_ff @(posedge clock) begin
		if (drawCard) begin
			cardReg <= dealtCard;
			baseX <= originX;
			baseY <= originY;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			DS_IDLE: if (drawCard) nextState = DS_BLANK_START;
			DS_BLANK_START: nextState = DS_BLANK;
			DS_BLANK: if (blankDone) nextState = DS_RANK_START;
			DS_RANK_START: nextState = DS_RANK;
			DS_RANK: if (rankDone) nextState = DS_SUIT_START;
			DS_SUIT_START: nextState = DS_SUIT;
			DS_SUIT: if (suitDone) nextState = DS_IDLE;
			default: nextState = DS_IDLE;
		endcase
	end

	glyphRom glyphRom_inst (
		.clock(clock),
		.cardRank(cardRank),
		.cardSuit(cardSuit),
		.rankGlyph(rankGlyph),
		.suitGlyph(suitGlyph)
	);

	blankPainter blankPainter_inst (
		.clock(clock), .resetN(resetN), .start(blankStart),
		.originX(baseX), .originY(baseY),
		.xOut(blankX), .yOut(blankY), .pixelValid(blankValid), .done(blankDone)
	);

	glyphPainter rankPainter (
		.clock(clock), .resetN(resetN), .start(rankStart),
		.originX(baseX + xCoord'(`GLYPH_X_OFFSET)), .originY(baseY + yCoord'(`RANK_Y_OFFSET)),
		.glyphData(rankGlyph),
		.xOut(rankX), .yOut(rankY), .colourOut(rankColour),
		.pixelValid(rankValid), .done(rankDone)
	);

	glyphPainter suitPainter (
		.clock(clock), .resetN(resetN), .start(suitStart),
		.originX(baseX + xCoord'(`GLYPH_X_OFFSET)), .originY(baseY + yCoord'(`SUIT_Y_OFFSET)),
		.glyphData(suitGlyph),
		.xOut(suitX), .yOut(suitY), .colourOut(suitColour),
		.pixelValid(suitValid), .done(suitDone)
	);

	// Registered pixel output mux
	always_ff @(posedge clock) begin
		if (!resetN) begin
			state <= DS_IDLE;
			x <= '0;
			y <= '0;
			pixelColour <= '0;
			plot <= 1'b0;
			cardDrawn <= 1'b0;
		end else begin
			state <= nextState;
			cardDrawn <= (state == DS_SUIT) && suitDone;
			plot <= 1'b0;
			if (state == DS_BLANK && blankValid) begin
				x <= blankX;
				y <= blankY;
				pixelColour <= colour'(`BLANK_COLOUR);
				plot <= 1'b1;
			end else if (state == DS_RANK && rankValid) begin
				x <= rankX;
				y <= rankY;
				pixelColour <= rankColour;
				plot <= 1'b1;
			end else if (state == DS_SUIT && suitValid) begin
				x <= suitX;
				y <= suitY;
				pixelColour <= suitColour;
				plot <= 1'b1;
			end
		end
	end

endmodule

// File: hw/cardDealer.sv
`timescale 1ns/1ns
`include "warDefs_defs.svh"

module cardDealer (
	input logic clock,
	input logic resetN,
	input logic nextCard,
	output cardPkg::card dealtCard
);
	import cardPkg::*;

	logic [15:0] lfsr;
	logic [3:0] rankBits;
	rank cardRank;
	suit cardSuit;

	// Maximal length polynomial x^16 + x^14 + x^13 + x^11
	always_ff @(posedge clock) begin
		if (!resetN)
			lfsr <= `LFSR_SEED;
		else
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
	end

	assign rankBits = lfsr[5:2];
	assign cardSuit = lfsr[1:0];
	assign cardRank = ((rankBits >= 4'd13) ? rankBits - 4'd13 : rankBits) + 4'd1; // Fold into 1..13

	always_ff @(posedge clock) begin
		if (nextCard)
			dealtCard <= {cardRank, cardSuit};
	end

endmodule

// File: hw/gameControl.sv
`timescale 1ns/1ns
`include "warDefs_defs.svh"

module gameControl (
	input logic clock,
	input logic resetN,
	input logic deal,
	input logic cardDrawn,
	input cardPkg::card dealtCard,
	output logic nextCard,
	output logic drawCard,
	output cardPkg::xCoord originX,
	output cardPkg::yCoord originY,
	output cardPkg::card playerCard,
	output cardPkg::card comCard,
	output gamePkg::winner roundWinner
);
	import cardPkg::*;
	import gamePkg::*;

	roundState state, nextState;
	rank playerRank;
	rank comRank;

	assign playerRank = playerCard[5:2];
	assign comRank = comCard[5:2];

	assign nextCard = (state == RS_DEAL_PLAYER) || (state == RS_DEAL_COM);
	assign drawCard = (state == RS_DRAW_PLAYER) || (state == RS_DRAW_COM);

	always_comb begin
		nextState = state;
		case (state)
			RS_WAIT_DEAL, RS_HOLD: if (deal) nextState = RS_WAIT_RELEASE;
			RS_WAIT_RELEASE: if (!deal) nextState = RS_DEAL_PLAYER; // Round starts on release
			RS_DEAL_PLAYER: nextState = RS_DRAW_PLAYER;
			RS_DRAW_PLAYER: nextState = RS_WAIT_PLAYER;
			RS_WAIT_PLAYER: if (cardDrawn) nextState = RS_DEAL_COM;
			RS_DEAL_COM: nextState = RS_DRAW_COM;
			RS_DRAW_COM: nextState = RS_WAIT_COM;
			RS_WAIT_COM: if (cardDrawn) nextState = RS_DECIDE;
			RS_DECIDE: nextState = RS_HOLD;
			default: nextState = RS_WAIT_DEAL;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!resetN) begin
			state <= RS_WAIT_DEAL;
			roundWinner <= WIN_NONE;
		end else begin
			state <= nextState;
			if ((state == RS_WAIT_DEAL || state == RS_HOLD) && deal)
				roundWinner <= WIN_NONE; // New press clears the old result
			else if (state == RS_DECIDE) begin
				if (playerRank > comRank)
					roundWinner <= WIN_PLAYER;
				else if (playerRank < comRank)
					roundWinner <= WIN_COM;
				else
					roundWinner <= WIN_TIE; // Suits never break a tie
			end
		end
	end

	// Card capture and screen position
	always_ff @(posedge clock) begin
		case (state)
			RS_DEAL_PLAYER: begin
				originX <= xCoord'(`PLAYER_X);
				originY <= yCoord'(`CARD_Y);
			end
			RS_DEAL_COM: begin
				originX <= xCoord'(`COM_X);
				originY <= yCoord'(`CARD_Y);
			end
			RS_DRAW_PLAYER: playerCard <= dealtCard; // Dealer output settled by now
			RS_DRAW_COM: comCard <= dealtCard;
			default: ;
		endcase
	end

endmodule

// File: hw/warGame.sv
`timescale 1ns/1ns

module warGame (
	input logic clock,
	input logic resetN,
	input logic deal, // Press and release to play a round
	output cardPkg::xCoord x,
	output cardPkg::yCoord y,
	output cardPkg::colour pixelColour,
	output logic plot,
	output cardPkg::card playerCard,
	output cardPkg::card comCard,
	output gamePkg::winner roundWinner
);
	import cardPkg::*;

	logic nextCard;
	logic drawCard;
	logic cardDrawn;
	card dealtCard;
	xCoord originX;
	yCoord originY;

	gameControl gameControl_inst (
		.clock(clock),
		.resetN(resetN),
		.deal(deal),
		.cardDrawn(cardDrawn),
		.dealtCard(dealtCard),
		.nextCard(nextCard),
		.drawCard(drawCard),
		.originX(originX),
		.originY(originY),
		.playerCard(playerCard),
		.comCard(comCard),
		.roundWinner(roundWinner)
	);

	cardDealer cardDealer_inst (
		.clock(clock),
		.resetN(resetN),
		.nextCard(nextCard),
		.dealtCard(dealtCard)
	);

	cardRenderer cardRenderer_inst (
		.clock(clock),
		.resetN(resetN),
		.drawCard(drawCard),
		.originX(originX),
		.originY(originY),
		.dealtCard(dealtCard),
		.x(x),
		.y(y),
		.pixelColour(pixelColour),
		.plot(plot),
		.cardDrawn(cardDrawn)
	);

endmodule

// File: bench/warGameTb.sv
`timescale 1ns/1ns
`include "warDefs_defs.svh"

module warGameTb;
	import cardPkg::*;
	import gamePkg::*;

	localparam int CLOCK_PERIOD = 8;
	localparam int ROUNDS = 24;
	localparam int BLANK_PIXELS = `CARD_WIDTH * `CARD_HEIGHT;
	localparam int GLYPH_PIXELS = `GLYPH_SIZE * `GLYPH_SIZE;
	localparam int CARD_PIXELS = BLANK_PIXELS + 2 * GLYPH_PIXELS;
	localparam int CARD_TIMEOUT = 4000; // Cycles allowed for both cards of a round

	logic clock, resetN, deal;
	xCoord x;
	yCoord y;
	colour pixelColour;
	logic plot;
	card playerCard, comCard;
	winner roundWinner;

	integer seed = 60600;
	int errors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int pixIdx = 0; // Position within the card being drawn
	int cardsSeen = 0;
	int playerWins = 0;
	int comWins = 0;
	int ties = 0;
	string curTest = "reset";

	warGame warGame_inst (
		.clock(clock), .resetN(resetN), .deal(deal),
		.x(x), .y(y), .pixelColour(pixelColour), .plot(plot),
		.playerCard(playerCard), .comCard(comCard), .roundWinner(roundWinner)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(ROUNDS * 5000 * CLOCK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", ROUNDS * 5000);
		$display("RESULT: FAIL");
		$finish;
	end

	task automatic reportMismatch(input string what, input int expected, input int actual);
		$display("FAIL %s %s: expected %0d, actual %0d", curTest, what, expected, actual);
		errors++;
	endtask

	task automatic reportProblem(input string msg);
		$display("%s: %s", curTest, msg);
		errors++;
	endtask

	// Checks every plotted pixel against its place in the card
	always @(negedge clock) begin : pixelMonitor
		int ox, oy, ex, ey, q;
		if (resetN && plot) begin
			ox = (cardsSeen % 2 == 0) ? `PLAYER_X : `COM_X;
			oy = `CARD_Y;
			if (pixIdx < BLANK_PIXELS) begin
				ex = ox + pixIdx % `CARD_WIDTH;
				ey = oy + pixIdx / `CARD_WIDTH;
				assert (int'(pixelColour) == `BLANK_COLOUR)
					else reportMismatch($sformatf("blank colour pixel %0d", pixIdx),
						`BLANK_COLOUR, pixelColour);
			end else if (pixIdx < BLANK_PIXELS + GLYPH_PIXELS) begin
				q = pixIdx - BLANK_PIXELS;
				ex = ox + `GLYPH_X_OFFSET + q % `GLYPH_SIZE;
				ey = oy + `RANK_Y_OFFSET + q / `GLYPH_SIZE;
			end else begin
				q = pixIdx - BLANK_PIXELS - GLYPH_PIXELS;
				ex = ox + `GLYPH_X_OFFSET + q % `GLYPH_SIZE;
				ey = oy + `SUIT_Y_OFFSET + q / `GLYPH_SIZE;
			end
			assert (int'(x) == ex)
				else reportMismatch($sformatf("x of card %0d pixel %0d", cardsSeen, pixIdx), ex, x);
			assert (int'(y) == ey)
				else reportMismatch($sformatf("y of card %0d pixel %0d", cardsSeen, pixIdx), ey, y);
			if (pixIdx == CARD_PIXELS - 1) begin
				pixIdx = 0;
				cardsSeen++;
			end else
				pixIdx++;
		end
	end

	// Holds deal for the given cycles while the old result must read as none
	task automatic pressDeal(input int hold);
		deal = 1'b1;
		repeat (hold) begin
			@(negedge clock);
			assert (roundWinner == WIN_NONE)
				else reportMismatch("winner during deal", WIN_NONE, roundWinner);
			assert (!plot) else reportProblem("plot went high before the deal was released");
		end
		deal = 1'b0;
	endtask

	task automatic playRound(input int r);
		int waitCycles, target, errorsBefore, pr, cr, idle;
		winner expected;
		winner held;
		curTest = $sformatf("round%0d", r);
		errorsBefore = errors;
		pressDeal(1 + $unsigned($random(seed)) % 8);
		target = 2 * (r + 1);
		if (r % 2 == 1) begin
			repeat (100 + $unsigned($random(seed)) % 800) @(negedge clock);
			deal = 1'b1; // Stray press while the first card is drawn
			repeat (2) @(negedge clock);
			deal = 1'b0;
		end
		waitCycles = 0;
		while (cardsSeen < target && waitCycles < CARD_TIMEOUT) begin
			@(negedge clock);
			waitCycles++;
		end
		assert (cardsSeen == target && pixIdx == 0)
			else reportProblem("the two cards of the round were not drawn completely");
		waitCycles = 0;
		while (roundWinner == WIN_NONE && waitCycles < 12) begin
			@(negedge clock);
			waitCycles++;
		end
		pr = playerCard[5:2];
		cr = comCard[5:2];
		assert (pr >= 1 && pr <= 13)
			else reportProblem($sformatf("player rank %0d is outside 1 to 13", pr));
		assert (cr >= 1 && cr <= 13)
			else reportProblem($sformatf("computer rank %0d is outside 1 to 13", cr));
		if (pr > cr)
			expected = WIN_PLAYER;
		else if (pr < cr)
			expected = WIN_COM;
		else
			expected = WIN_TIE; // Suits are ignored
		assert (roundWinner == expected)
			else reportMismatch("winner", expected, roundWinner);
		held = roundWinner;
		idle = 5 + $unsigned($random(seed)) % 16;
		repeat (idle) begin
			@(negedge clock);
			assert (roundWinner == held) else reportMismatch("held winner", held, roundWinner);
			assert (!plot) else reportProblem("extra pixels after the round ended");
		end
		case (roundWinner)
			WIN_PLAYER: playerWins++;
			WIN_COM: comWins++;
			WIN_TIE: ties++;
			default: ;
		endcase
		testsRun++;
		if (errors != errorsBefore)
			testsFailed++;
		$display("%s: player rank %0d, com rank %0d, winner %s, %s", curTest, pr, cr,
			roundWinner.name(), (errors == errorsBefore) ? "ok" : "failed");
	endtask

	initial begin
		int outcomes;
		int errorsBefore;
		resetN = 1'b0;
		deal = 1'b0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		resetN = 1'b1;
		assert (!plot) else reportProblem("plot is high after reset");
		assert (x == '0 && y == '0) else reportProblem("pixel position is not 0 after reset");
		assert (pixelColour == '0) else reportMismatch("colour after reset", 0, pixelColour);
		repeat (20) begin
			@(negedge clock);
			assert (!plot) else reportProblem("plot went high with no deal");
			assert (roundWinner == WIN_NONE)
				else reportMismatch("winner before first deal", WIN_NONE, roundWinner);
		end
		testsRun++;
		if (errors != 0)
			testsFailed++;
		$display("reset: %s", (errors == 0) ? "ok" : "failed");
		for (int r = 0; r < ROUNDS; r++)
			playRound(r);
		curTest = "outcomes";
		errorsBefore = errors;
		outcomes = (playerWins > 0) + (comWins > 0) + (ties > 0);
		assert (outcomes >= 2) else reportProblem("all rounds ended with the same outcome");
		testsRun++;
		if (errors != errorsBefore)
			testsFailed++;
		$display("outcomes: %0d different, %s", outcomes,
			(errors == errorsBefore) ? "ok" : "failed");
		$display("tests %0d, failed %0d, errors %0d, player wins %0d, com wins %0d, ties %0d",
			testsRun, testsFailed, errors, playerWins, comWins, ties);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: src.f
+incdir+include
hw/cardPkg.sv
hw/gamePkg.sv
hw/glyphRom.sv
hw/blankPainter.sv
hw/glyphPainter.sv
hw/cardRenderer.sv
hw/cardDealer.sv
hw/gameControl.sv
hw/warGame.sv
bench/warGameTb.sv

// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = warGameTb
FILELIST = src.f
OBJDIR = obj_dir
BIN = $(OBJDIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJDIR)
